// File: tb.f
+incdir+hdl
hdl/enc_pkg.sv
hdl/enc_debounce.sv
hdl/enc_quad_counter.sv
hdl/enc_period_meter.sv
hdl/enc_bus_ctrl.sv
hdl/enc_top.sv
sim/tb_enc_top.sv

// File: Bender.yml
package:
  name: enc_if

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/enc_pkg.sv
      - hdl/enc_debounce.sv
      - hdl/enc_quad_counter.sv
      - hdl/enc_period_meter.sv
      - hdl/enc_bus_ctrl.sv
      - hdl/enc_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_enc_top.sv

// File: sim/tb_enc_top.sv
// self-checking testbench for enc_top, random encoder motion checked against a model over the host port
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module tb_enc_top import enc_pkg::*; ();

    localparam int NCH       = `ENC_NUM_CHAN;
    localparam int STEP_HOLD = `ENC_DEB_LEN + 6;    // cycles each encoder step is held
    localparam int MAX_STEPS = 200;                 // bound on steps over all tests
    localparam int WDOG_CYC  = MAX_STEPS * STEP_HOLD * 2 + 2000;
    localparam int ACK_WAIT  = 8;                   // give up on ack after this many cycles

    logic           sysclk;
    logic           reset;
    logic           req;
    logic           we;
    enc_addr_t      addr;
    logic [31:0]    wdata;
    logic           ack;
    logic [31:0]    rdata;
    logic [NCH-1:0] enc_a;
    logic [NCH-1:0] enc_b;

    // encoder and register model
    logic [1:0]  phase   [NCH];     // gray phase, 0..3 = ab 00 10 11 01
    enc_count_t  exp_cnt [NCH];
    enc_count_t  exp_pre [NCH];
    logic        exp_ovf [NCH];
    logic [31:0] rng;
    int          errors       = 0;
    int          proto_errors = 0;
    int          checks       = 0;
    int          n_loads      = 0;
    int          load_pulses  = 0;

    enc_top u_dut (
        .sysclk (sysclk),
        .reset  (reset),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .enc_a  (enc_a),
        .enc_b  (enc_b)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;   // 40 ns period
    end

    initial
    begin
        repeat (WDOG_CYC) @(posedge sysclk);
        $display("watchdog expired, the run did not finish within %0d cycles", WDOG_CYC);
        $display("Test failed");
        $finish;
    end

    // strobe cycles, one expected per LOAD write
    always @(negedge sysclk)
        if (reset && (u_dut.load != '0))
            load_pulses++;

    // ------------------------------------------------------------------------
    // random numbers and encoder stimulus
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_word();
        rng = rng * 32'd1664525 + 32'd1013904223;   // LCG step
        return rng;
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r[30:8]) % n;                   // skip the weak low bits
    endfunction

    // n steps in one direction, model updated per step
    task automatic step_chan(input int ch, input bit up, input int n);
        repeat (n)
        begin
            if (up)
            begin
                if (exp_cnt[ch] == '1)
                    exp_ovf[ch] = 1'b1;             // wraps to zero
                exp_cnt[ch] = exp_cnt[ch] + 1'b1;
                phase[ch]   = phase[ch] + 2'd1;
            end
            else
            begin
                if (exp_cnt[ch] == '0)
                    exp_ovf[ch] = 1'b1;             // wraps to all ones
                exp_cnt[ch] = exp_cnt[ch] - 1'b1;
                phase[ch]   = phase[ch] - 2'd1;
            end
            enc_a[ch] = (phase[ch] == 2'd1) || (phase[ch] == 2'd2);
            enc_b[ch] = phase[ch][1];
            repeat (STEP_HOLD) @(negedge sysclk);
        end
    endtask

    // ------------------------------------------------------------------------
    // host transactions
    // ------------------------------------------------------------------------
    task automatic bus_xfer(input bit wr, input int ch, input logic [3:0] off,
                            input logic [31:0] data, output logic [31:0] result);
        enc_addr_t a;
        int        wait_cyc;
        a.f.chan   = 4'(ch);
        a.f.offset = off;
        assert (!ack) else
        begin
            proto_errors++;
            $display("at %0t ack was still high before a new request", $time);
        end
        addr  = a;
        we    = wr;
        wdata = data;
        req   = 1'b1;
        wait_cyc = 0;
        @(negedge sysclk);
        while (!ack && (wait_cyc < ACK_WAIT))
        begin
            @(negedge sysclk);
            wait_cyc++;
        end
        assert (ack && (wait_cyc == 0)) else
        begin
            proto_errors++;
            $display("at %0t ack did not rise one cycle after req", $time);
        end
        repeat (pick(4))                            // host stall, ack must hold
        begin
            @(negedge sysclk);
            assert (ack) else
            begin
                proto_errors++;
                $display("at %0t ack dropped while req was still held", $time);
            end
        end
        result = rdata;
        req    = 1'b0;
        wait_cyc = 0;
        @(negedge sysclk);
        while (ack && (wait_cyc < ACK_WAIT))
        begin
            @(negedge sysclk);
            wait_cyc++;
        end
        assert (!ack && (wait_cyc == 0)) else
        begin
            proto_errors++;
            $display("at %0t ack did not fall one cycle after req dropped", $time);
        end
        if (wr && (ch < NCH) && (off == `ENC_OFF_LOAD))
        begin
            exp_pre[ch] = data[`ENC_CNT_W-1:0];     // preload lands in the count too
            exp_cnt[ch] = data[`ENC_CNT_W-1:0];
            exp_ovf[ch] = 1'b0;
            n_loads++;
        end
    endtask

    task automatic read_check(input int ch, input logic [3:0] off, input logic [31:0] exp);
        logic [31:0] got;
        bus_xfer(1'b0, ch, off, 32'd0, got);
        checks++;
        assert (got === exp) else
        begin
            errors++;
            $display("Mismatch at %0t: chan %0d offset %0d read %h, expected %h",
                     $time, ch, off, got, exp);
        end
    endtask

    task automatic check_chan(input int ch);
        read_check(ch, `ENC_OFF_DATA, 32'({exp_ovf[ch], exp_cnt[ch]}));
        read_check(ch, `ENC_OFF_LOAD, 32'(exp_pre[ch]));
    endtask

    // period is only good to one tick, edge phase against the prescaler
    task automatic period_check(input int ch, input int exp);
        logic [31:0] got;
        int          diff;
        bus_xfer(1'b0, ch, `ENC_OFF_PER, 32'd0, got);
        diff = int'(got) - exp;
        checks++;
        assert ((diff >= -1) && (diff <= 1)) else
        begin
            errors++;
            $display("Mismatch at %0t: chan %0d period %0d, expected %0d +-1",
                     $time, ch, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int          ch;
        logic [31:0] dummy;
        reset = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        enc_a = '0;
        enc_b = '0;
        rng   = 32'h2353;
        for (int i = 0; i < NCH; i++)
        begin
            phase[i]   = 2'd0;
            exp_cnt[i] = '0;
            exp_pre[i] = '0;
            exp_ovf[i] = 1'b0;
        end
        repeat (16) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b1;
        @(negedge sysclk);

        // everything reads zero out of reset
        for (int i = 0; i < NCH; i++)
        begin
            check_chan(i);
            read_check(i, `ENC_OFF_PER, 32'd0);
        end

        // random walk, all channels checked after each move
        repeat (12)
        begin
            ch = pick(NCH);
            step_chan(ch, pick(2) == 1, 1 + pick(8));
            for (int i = 0; i < NCH; i++)
                check_chan(i);
        end

        // preload then move
        for (int i = 0; i < NCH; i++)
        begin
            bus_xfer(1'b1, i, `ENC_OFF_LOAD, rand_word(), dummy);
            check_chan(i);
            step_chan(i, pick(2) == 1, 1 + pick(8));
            check_chan(i);
        end
        bus_xfer(1'b1, 0, 4'h3, 32'hdead_beef, dummy);          // unmapped offset
        bus_xfer(1'b1, NCH, `ENC_OFF_LOAD, 32'h0012_3456, dummy); // no such channel
        read_check(0, 4'h3, 32'd0);
        for (int off = 0; off < 3; off++)
            read_check(NCH, 4'(off), 32'd0);
        for (int i = 0; i < NCH; i++)
            check_chan(i);

        // wrap both ways, load clears ovf
        ch = pick(NCH);
        bus_xfer(1'b1, ch, `ENC_OFF_LOAD, 32'h00ff_ffff, dummy);
        step_chan(ch, 1'b1, 2);
        check_chan(ch);
        bus_xfer(1'b1, ch, `ENC_OFF_LOAD, 32'd0, dummy);
        check_chan(ch);
        step_chan(ch, 1'b0, 3);
        check_chan(ch);
        bus_xfer(1'b1, ch, `ENC_OFF_LOAD, rand_word(), dummy);
        check_chan(ch);

        // steady forward motion, three B cycles per channel
        for (int i = 0; i < NCH; i++)
        begin
            step_chan(i, 1'b1, 12);
            period_check(i, (4 * STEP_HOLD) / `ENC_PRESCALE);
            check_chan(i);
        end

        checks++;
        assert (load_pulses == n_loads) else
        begin
            errors++;
            $display("Mismatch at %0t: %0d load strobe cycles for %0d LOAD writes",
                     $time, load_pulses, n_loads);
        end

        $display("%0d checks, %0d mismatches, %0d protocol errors",
                 checks, errors, proto_errors);
        if ((errors == 0) && (proto_errors == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/enc_top.sv
// encoder interface top, host register port plus four filtered encoder channels
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_top import enc_pkg::*; (
    input  logic                     sysclk,
    input  logic                     reset,     // sync, active low
    input  logic                     req,
    input  logic                     we,
    input  enc_addr_t                addr,
    input  logic [31:0]              wdata,
    output logic                     ack,
    output logic [31:0]              rdata,
    input  logic [`ENC_NUM_CHAN-1:0] enc_a,     // raw encoder lines
    input  logic [`ENC_NUM_CHAN-1:0] enc_b
);

    localparam int NCH = `ENC_NUM_CHAN;

    logic [NCH-1:0] a_filt;           // after debounce
    logic [NCH-1:0] b_filt;
    logic [NCH-1:0] load;
    logic [NCH-1:0] ovf;
    enc_count_t     preload [NCH];
    enc_count_t     count   [NCH];
    enc_period_t    period  [NCH];

    // ------------------------------------------------------------------------
    // register file side
    // ------------------------------------------------------------------------
    enc_bus_ctrl u_ctrl (
        .sysclk  (sysclk),
        .reset   (reset),
        .req     (req),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .load    (load),
        .preload (preload),
        .count   (count),
        .ovf     (ovf),
        .period  (period)
    );

    // ------------------------------------------------------------------------
    // channel slices
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < NCH; i++)
    begin : g_chan
        enc_debounce u_deb_a (.sysclk(sysclk), .reset(reset), .din(enc_a[i]), .dout(a_filt[i]));
        enc_debounce u_deb_b (.sysclk(sysclk), .reset(reset), .din(enc_b[i]), .dout(b_filt[i]));

        enc_quad_counter u_quad (
            .sysclk  (sysclk),
            .reset   (reset),
            .enc_a   (a_filt[i]),
            .enc_b   (b_filt[i]),
            .load    (load[i]),
            .preload (preload[i]),
            .count   (count[i]),
            .ovf     (ovf[i]),
            .dir     ()                   // no register maps direction
        );

        enc_period_meter u_per (.sysclk(sysclk), .reset(reset), .enc_b(b_filt[i]),
                                .period(period[i]));
    end

endmodule

`default_nettype wire

// File: hdl/enc_bus_ctrl.sv
// host register access: four-phase req/ack handshake, preload registers and read mux
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_bus_ctrl import enc_pkg::*; (
    input  logic                     sysclk,
    input  logic                     reset,     // sync, active low
    input  logic                     req,       // host request, held until ack
    input  logic                     we,        // 1 = write
    input  enc_addr_t                addr,
    input  logic [31:0]              wdata,
    output logic                     ack,
    output logic [31:0]              rdata,     // valid while ack is high
    output logic [`ENC_NUM_CHAN-1:0] load,      // preload strobes, one-hot
    output enc_count_t               preload [`ENC_NUM_CHAN],
    input  enc_count_t               count   [`ENC_NUM_CHAN],
    input  logic [`ENC_NUM_CHAN-1:0] ovf,
    input  enc_period_t              period  [`ENC_NUM_CHAN]
);

    localparam int NCH   = `ENC_NUM_CHAN;
    localparam int SEL_W = $clog2(NCH);

    logic             start;          // first edge of a new request
    logic             chan_ok;        // channel field is in range
    logic [SEL_W-1:0] sel;
    logic             load_hit;
    logic [31:0]      rd_word;

    assign start    = req && !ack;
    assign chan_ok  = (addr.f.chan < 4'(NCH));
    assign sel      = addr.f.chan[SEL_W-1:0];
    assign load_hit = we && chan_ok && (addr.f.offset == `ENC_OFF_LOAD);

    // ------------------------------------------------------------------------
    // read mux, unmapped space reads zero
    // ------------------------------------------------------------------------
    always_comb
    begin
        rd_word = '0;
        if (chan_ok)
        begin
            case (addr.f.offset)
                `ENC_OFF_LOAD: rd_word = 32'(preload[sel]);
                `ENC_OFF_DATA: rd_word = 32'({ovf[sel], count[sel]});  // ovf on top
                `ENC_OFF_PER:  rd_word = 32'(period[sel]);
                default:       rd_word = '0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // handshake, preload writes and load strobes
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            ack  <= 1'b0;
            load <= '0;
            for (int i = 0; i < NCH; i++)
                preload[i] <= '0;
        end
        else
        begin
            load <= '0;                             // strobe lasts one cycle
            if (start)
            begin
                ack <= 1'b1;
                if (load_hit)
                begin
                    preload[sel] <= wdata[`ENC_CNT_W-1:0];
                    load[sel]    <= 1'b1;           // rises with ack
                end
            end
            else if (!req)
                ack <= 1'b0;                        // host let go
        end
    end

    // read data, captured once per request
    always_ff @(posedge sysclk)
    begin
        if (start && !we)
            rdata <= rd_word;
    end

    a_ack_needs_req: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(ack) |-> $past(req));

    a_load_onehot: assert property (@(posedge sysclk) disable iff (!reset)
        $onehot0(load));

endmodule

`default_nettype wire

// File: hdl/enc_period_meter.sv
// encoder period meter, counts prescaled ticks between rising edges of filtered B
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_period_meter import enc_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,        // sync, active low
    input  logic        enc_b,        // filtered B
    output enc_period_t period        // ticks over the last full B cycle
);

    localparam int PRE_W = $clog2(`ENC_PRESCALE);
    localparam logic [PRE_W-1:0] PRE_END = PRE_W'(`ENC_PRESCALE - 1);

    logic [PRE_W-1:0] pre_cnt;        // prescaler
    logic             tick;
    logic             b_prev;
    logic             b_rise;
    enc_period_t      running;        // ticks since the last rising edge

    assign tick   = (pre_cnt == PRE_END);
    assign b_rise = enc_b & ~b_prev;

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            pre_cnt <= '0;
            b_prev  <= 1'b0;
            running <= '0;
            period  <= '0;
        end
        else
        begin
            b_prev <= enc_b;
            if (b_rise)
            begin
                period  <= running;             // end of one measurement
                running <= '0;
                pre_cnt <= '0;                  // tick phase restarts too
            end
            else
            begin
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                if (tick && (running != '1))
                    running <= running + 1'b1;  // stops at all ones
            end
        end
    end

    // stopped encoder must read as full scale, never roll back to zero
    a_no_wrap: assert property (@(posedge sysclk) disable iff (!reset)
        ((running == '1) && !b_rise) |=> (running == '1));

endmodule

`default_nettype wire

// File: hdl/enc_quad_counter.sv
// x4 quadrature decoder and preloadable position counter, one per channel
`timescale 1ns/1ps
`default_nettype none

module enc_quad_counter import enc_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,         // sync, active low
    input  logic       enc_a,         // filtered A
    input  logic       enc_b,         // filtered B
    input  logic       load,          // one-cycle preload strobe
    input  enc_count_t preload,
    output enc_count_t count,
    output logic       ovf,           // sticky, cleared by load
    output logic       dir            // direction of the last step, 1 = up
);

    logic a_prev;
    logic b_prev;
    logic step;
    logic up;

    // ------------------------------------------------------------------------
    // transition decode
    // ------------------------------------------------------------------------
    // exactly one line moved; both moving is an illegal jump and is dropped
    assign step = (enc_a ^ a_prev) ^ (enc_b ^ b_prev);

    // A leading B counts up: 00 -> 10 -> 11 -> 01 -> 00
    assign up = enc_a ^ b_prev;

    // ------------------------------------------------------------------------
    // counter
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            a_prev <= 1'b0;                 // filters also come up low
            b_prev <= 1'b0;
            count  <= '0;
            ovf    <= 1'b0;
            dir    <= 1'b0;
        end
        else
        begin
            a_prev <= enc_a;
            b_prev <= enc_b;
            if (load)
            begin
                count <= preload;           // host preload wins over a step
                ovf   <= 1'b0;
            end
            else if (step)
            begin
                dir <= up;
                if (up)
                begin
                    count <= count + 1'b1;
                    if (count == '1)
                        ovf <= 1'b1;        // wrapped past all ones
                end
                else
                begin
                    count <= count - 1'b1;
                    if (count == '0)
                        ovf <= 1'b1;        // wrapped below zero
                end
            end
        end
    end

    // quiet lines and no load leave the position alone
    a_count_hold: assert property (@(posedge sysclk) disable iff (!reset)
        (!load && (enc_a == a_prev) && (enc_b == b_prev)) |=> $stable(count));

endmodule

`default_nettype wire

// File: hdl/enc_debounce.sv
// glitch filter for one raw encoder line, one instance per A and per B line
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_debounce (
    input  logic sysclk,
    input  logic reset,               // sync, active low
    input  logic din,                 // raw line, async to sysclk
    output logic dout                 // filtered level
);

    localparam int CNT_W = $clog2(`ENC_DEB_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`ENC_DEB_LEN - 1);

    logic [1:0]       sync;           // two-flop synchronizer, [1] is safe
    logic [CNT_W-1:0] stable_cnt;     // cycles the new level has held
    logic             at_end;

    assign at_end = (stable_cnt == CNT_END);

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            sync       <= 2'b00;
            stable_cnt <= '0;
            dout       <= 1'b0;
        end
        else
        begin
            sync <= {sync[0], din};
            if (sync[1] == dout)
                stable_cnt <= '0;                   // nothing pending
            else if (at_end)
            begin
                dout       <= sync[1];              // held long enough
                stable_cnt <= '0;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // output only moves once a pending level has run the full count
    a_dout_stable: assert property (@(posedge sysclk) disable iff (!reset)
        $changed(dout) |-> $past(at_end && (sync[1] != dout)));

endmodule

`default_nettype wire

// File: hdl/enc_pkg.sv
// shared types for the encoder interface, imported by the RTL and the testbench
`default_nettype none

`include "enc_macros.svh"

package enc_pkg;

    // position word from the quadrature counter, unsigned wrap
    typedef logic [`ENC_CNT_W-1:0] enc_count_t;

    // period word, prescaled ticks between B rising edges
    typedef logic [`ENC_PER_W-1:0] enc_period_t;

    // host address split into its two fields
    typedef struct packed {
        logic [3:0] chan;         // channel select
        logic [3:0] offset;       // register within the channel
    } enc_addr_fields_t;

    // same byte seen flat or as channel/offset
    typedef union packed {
        logic [7:0]       raw;
        enc_addr_fields_t f;
    } enc_addr_t;

endpackage

`default_nettype wire

// File: hdl/enc_macros.svh
// shared constants for the encoder interface, included by the RTL and the testbench
`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// ---------------------------------------------------------------------------
// channel layout
// ---------------------------------------------------------------------------
`define ENC_NUM_CHAN    4         // encoder channels behind the register file

// register offsets inside one channel, low nibble of the host address
`define ENC_OFF_LOAD    4'h0      // preload value, r/w
`define ENC_OFF_DATA    4'h1      // ovf at bit 24 over the position count
`define ENC_OFF_PER     4'h2      // last period measurement

// ---------------------------------------------------------------------------
// datapath sizing
// ---------------------------------------------------------------------------
`define ENC_DEB_LEN     4         // cycles a line must hold before it passes
`define ENC_PRESCALE    8         // sysclk cycles per period tick

`define ENC_CNT_W       24        // position count width
`define ENC_PER_W       16        // period width, saturates at all ones

`endif
